/* verilog/spi_pkg.sv */
// **************************************
// frame is one 32-bit word, lsb first
// address 7 and soft reset read as zero
// **************************************

package spi_pkg;

   localparam int SPI_DATA_W = 32;
   localparam int SPI_ADDR_W = 3;

   // bus word, also the width of TX, RX and scratch
   typedef logic [SPI_DATA_W-1:0] spi_data_t;
   typedef logic [SPI_ADDR_W-1:0] spi_addr_t;

   // counts sample ticks, must reach SPI_DATA_W
   typedef logic [5:0] spi_bitcnt_t;

   localparam spi_bitcnt_t SPI_FRAME_BITS = 6'(SPI_DATA_W);

   // register map
   localparam spi_addr_t ADDR_INTR_EN  = 3'd0;
   localparam spi_addr_t ADDR_READY    = 3'd1;
   localparam spi_addr_t ADDR_TX       = 3'd2;
   localparam spi_addr_t ADDR_RX       = 3'd3;
   localparam spi_addr_t ADDR_VERSION  = 3'd4;
   localparam spi_addr_t ADDR_SOFT_RST = 3'd5;
   localparam spi_addr_t ADDR_SCRATCH  = 3'd6;

   localparam spi_data_t SPI_VERSION_WORD = 32'h0002_0001;

   // frame sequencer
   typedef enum logic [1:0] {
      IDLE,
      LEAD,
      SHIFT,
      TRAIL
   } seq_state_t;

endpackage

/* verilog/spi_frame_if.sv */
// **************************************
// no handshakes, start and done are
// single clk pulses
// **************************************

`timescale 1ns/10ps

interface spi_frame_if import spi_pkg::*; ();

   logic      start;
   spi_data_t tx_word;
   spi_data_t rx_word;
   logic      done;
   logic      busy;
   logic      shift_tick;
   logic      sample_tick;
   logic      sreset;

   modport ctrl (
      output start,
      output tx_word,
      output sreset,
      input  rx_word,
      input  done,
      input  busy
   );

   modport seq (input start, input shift_tick, input sample_tick, output done, output busy);

   modport clkgen (input busy, input done, output shift_tick, output sample_tick);

   modport shift (input start, input tx_word, input shift_tick, input sample_tick, output rx_word);

endinterface

/* verilog/spi_regs.sv */
// **************************************
// data_out is combinational, TX writes
// while busy are dropped
// **************************************

`timescale 1ns/10ps

module spi_regs import spi_pkg::*; (
   input  logic      clk,
   input  logic      rst_int,
   input  logic      sel,
   input  logic      read,
   input  logic      write,
   input  spi_addr_t address,
   input  spi_data_t data_in,
   output spi_data_t data_out,
   output logic      interrupt,
   spi_frame_if.ctrl frame
);

   logic      wr_en;
   logic      rd_en;
   logic      ie_wr;
   logic      tx_wr;
   logic      rx_rd;
   logic      soft_rst_wr;
   logic      scratch_wr;
   logic      intr_en;
   logic      ready;
   spi_data_t tx_q;
   spi_data_t scratch_q;

   assign wr_en = sel & write;
   assign rd_en = sel & read;

   // write enables and read side effects
   always_comb begin
      ie_wr       = 1'b0;
      tx_wr       = 1'b0;
      rx_rd       = 1'b0;
      soft_rst_wr = 1'b0;
      scratch_wr  = 1'b0;
      case (address)
         ADDR_INTR_EN:  ie_wr = wr_en;
         ADDR_TX:       tx_wr = wr_en;
         ADDR_RX:       rx_rd = rd_en;
         ADDR_SOFT_RST: soft_rst_wr = wr_en;
         ADDR_SCRATCH:  scratch_wr = wr_en;
         default: ;
      endcase
   end

   // read mux
   always_comb begin
      case (address)
         ADDR_INTR_EN: data_out = {{(SPI_DATA_W-1){1'b0}}, intr_en};
         ADDR_READY:   data_out = {{(SPI_DATA_W-1){1'b0}}, ready};
         ADDR_TX:      data_out = tx_q;
         ADDR_RX:      data_out = frame.rx_word;
         ADDR_VERSION: data_out = SPI_VERSION_WORD;
         ADDR_SCRATCH: data_out = scratch_q;
         default:      data_out = '0;
      endcase
   end

   assign frame.start = tx_wr & ~frame.busy;

   // on the start cycle the bus word goes straight to the shifter,
   // which loads together with tx_q
   assign frame.tx_word = frame.start ? data_in : tx_q;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         tx_q      <= '0;
         scratch_q <= '0;
         intr_en   <= 1'b0;
      end else begin
         if (frame.start)
            tx_q <= data_in;
         if (scratch_wr)
            scratch_q <= data_in;
         if (ie_wr)
            intr_en <= data_in[0];
      end
   end

   // clear wins over done
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         ready <= 1'b1;
      else if (frame.start | rx_rd)
         ready <= 1'b0;
      else if (frame.done)
         ready <= 1'b1;
   end

   assign interrupt = intr_en & ready;

   // soft reset pulse, one clk after the write
   always_ff @(posedge clk) begin
      frame.sreset <= soft_rst_wr;
   end

endmodule

/* verilog/spi_clk_gen.sv */
// **************************************
// sclk half period is CLK_DIV clks,
// CLK_DIV must be 1 or more
// **************************************

`timescale 1ns/10ps

module spi_clk_gen #(
   parameter int CLK_DIV = 2
) (
   input  logic        clk,
   input  logic        rst_int,
   output logic        sclk,
   spi_frame_if.clkgen frame
);

   localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

   logic [CNT_W-1:0] cnt;
   logic             run;
   logic             half_end;

   // stop in the trailing state so no edge follows the last bit
   assign run      = frame.busy & ~frame.done;
   assign half_end = run && (cnt == CNT_W'(CLK_DIV - 1));

   // ticks mark the clk cycle ending in the sclk edge
   assign frame.sample_tick = half_end & ~sclk;
   assign frame.shift_tick  = half_end & sclk;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         cnt  <= '0;
         sclk <= 1'b0;
      end else if (!run) begin
         cnt  <= '0;
         sclk <= 1'b0;
      end else if (half_end) begin
         cnt  <= '0;
         sclk <= ~sclk;
      end else begin
         cnt <= cnt + CNT_W'(1);
      end
   end

endmodule

/* verilog/spi_frame_seq.sv */
// **************************************
// start is only accepted in IDLE
// **************************************

`timescale 1ns/10ps

module spi_frame_seq import spi_pkg::*; (
   input  logic     clk,
   input  logic     rst_int,
   output logic     ss,
   spi_frame_if.seq frame
);

   seq_state_t  state;
   spi_bitcnt_t bit_cnt;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state   <= IDLE;
         bit_cnt <= '0;
         ss      <= 1'b1;
      end else begin
         case (state)
            IDLE: begin
               if (frame.start) begin
                  state   <= LEAD;
                  bit_cnt <= '0;
                  ss      <= 1'b0;
               end
            end
            // LEAD holds until the first falling sclk
            LEAD, SHIFT: begin
               if (frame.sample_tick)
                  bit_cnt <= bit_cnt + 6'd1;
               if (frame.shift_tick) begin
                  if (bit_cnt == SPI_FRAME_BITS) begin
                     state <= TRAIL;
                     ss    <= 1'b1;
                  end else begin
                     state <= SHIFT;
                  end
               end
            end
            TRAIL:   state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   assign frame.busy = (state != IDLE);

   // ready and busy change together on the clk ending TRAIL
   assign frame.done = (state == TRAIL);

endmodule

/* verilog/spi_shifter.sv */
// **************************************
// lsb first on both lines, sampling on
// rising sclk
// **************************************

`timescale 1ns/10ps

module spi_shifter import spi_pkg::*; (
   input  logic       clk,
   input  logic       rst_int,
   input  logic       miso,
   output logic       mosi,
   spi_frame_if.shift frame
);

   spi_data_t tx_shift;
   spi_data_t rx_shift;

   // transmit side, empties to zero after the frame
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         tx_shift <= '0;
      else if (frame.start)
         tx_shift <= frame.tx_word;
      else if (frame.shift_tick)
         tx_shift <= tx_shift >> 1;
   end

   assign mosi = tx_shift[0];

   // receive side
   // first bit in ends up in bit 0
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         rx_shift <= '0;
      else if (frame.sample_tick)
         rx_shift <= {miso, rx_shift[SPI_DATA_W-1:1]};
   end

   assign frame.rx_word = rx_shift;

endmodule

/* verilog/spi_master_top.sv */
// **************************************
// single clock, mode 0 style frames,
// one slave select
// **************************************

`timescale 1ns/10ps

module spi_master_top import spi_pkg::*; #(
   parameter int CLK_DIV = 2
) (
   input  logic      clk,
   input  logic      rst_int,
   input  logic      sel,
   input  logic      read,
   input  logic      write,
   input  spi_addr_t address,
   input  spi_data_t data_in,
   output spi_data_t data_out,
   output logic      interrupt,
   output logic      sclk,
   output logic      ss,
   output logic      mosi,
   input  logic      miso
);

   logic core_rst;

   spi_frame_if frame ();

   // soft reset acts exactly like the external one
   assign core_rst = rst_int | frame.sreset;

   spi_regs u_regs (
      .clk       (clk),
      .rst_int   (core_rst),
      .sel       (sel),
      .read      (read),
      .write     (write),
      .address   (address),
      .data_in   (data_in),
      .data_out  (data_out),
      .interrupt (interrupt),
      .frame     (frame.ctrl)
   );

   spi_clk_gen #(
      .CLK_DIV (CLK_DIV)
   ) u_clk_gen (
      .clk     (clk),
      .rst_int (core_rst),
      .sclk    (sclk),
      .frame   (frame.clkgen)
   );

   spi_frame_seq u_seq (
      .clk     (clk),
      .rst_int (core_rst),
      .ss      (ss),
      .frame   (frame.seq)
   );

   spi_shifter u_shifter (
      .clk     (clk),
      .rst_int (core_rst),
      .miso    (miso),
      .mosi    (mosi),
      .frame   (frame.shift)
   );

endmodule

/* bench/spi_asserts.sv */
// **************************************
// bound into spi_frame_seq, uses its
// state, ss and frame signals
// **************************************

`timescale 1ns/10ps

module spi_asserts import spi_pkg::*; (
   input logic       clk,
   input logic       rst_int,
   input seq_state_t state,
   input logic       ss,
   input logic       busy,
   input logic       done,
   input logic       shift_tick,
   input logic       sample_tick
);

   // failed assertion count
   int fail_cnt = 0;

   // slave select follows busy, TRAIL already has ss high
   idle_ss_high: assert property (@(posedge clk) disable iff (rst_int)
      !busy |-> ss)
      else begin
         fail_cnt++;
         $error("ss low while the sequencer is idle");
      end

   frame_ss_low: assert property (@(posedge clk) disable iff (rst_int)
      (busy && !done) |-> !ss)
      else begin
         fail_cnt++;
         $error("ss high during a frame");
      end

   // done lasts one clk and the sequencer goes back to IDLE
   done_single: assert property (@(posedge clk) disable iff (rst_int)
      done |=> (!done && state == IDLE))
      else begin
         fail_cnt++;
         $error("done is not a single pulse");
      end

   ticks_apart: assert property (@(posedge clk) disable iff (rst_int)
      !(shift_tick && sample_tick))
      else begin
         fail_cnt++;
         $error("shift and sample ticks coincide");
      end

endmodule

/* bench/spi_checker.sv */
// **************************************
// reference model of the register map,
// checks reads, outputs and each frame
// **************************************

`timescale 1ns/10ps

module spi_checker import spi_pkg::*; #(
   parameter int CLK_DIV = 2
) (
   input logic      clk,
   input logic      rst_int,
   input logic      sel,
   input logic      read,
   input logic      write,
   input spi_addr_t address,
   input spi_data_t data_in,
   input spi_data_t data_out,
   input logic      interrupt,
   input logic      sclk,
   input logic      ss,
   input logic      mosi,
   input spi_data_t mosi_word,
   input spi_data_t miso_word
);

   spi_data_t tx_m;
   spi_data_t rx_m;
   spi_data_t scratch_m;
   logic      ie_m;
   logic      ready_m;
   logic      busy_m;
   logic      seen_low;
   logic      ss_q = 1'b1;
   int        rises = 0;
   int        low_cycles = 0;
   int        falls = 0;
   int        frames = 0;
   int        err_total = 0;
   int        test_errs = 0;
   int        tests = 0;
   int        tests_failed = 0;

   function automatic spi_data_t read_model(spi_addr_t a);
      case (a)
         ADDR_INTR_EN: return {31'b0, ie_m};
         ADDR_READY:   return {31'b0, ready_m};
         ADDR_TX:      return tx_m;
         ADDR_RX:      return rx_m;
         ADDR_VERSION: return SPI_VERSION_WORD;
         ADDR_SCRATCH: return scratch_m;
         default:      return '0;
      endcase
   endfunction

   task automatic value_err(string name, spi_data_t exp, spi_data_t act);
      $display("ERR %s expected %08h actual %08h", name, exp, act);
      err_total++;
      test_errs++;
   endtask

   task automatic plain_fail(string msg);
      $display("failure: %s", msg);
      err_total++;
      test_errs++;
   endtask

   task automatic clear_model();
      tx_m      = '0;
      rx_m      = '0;
      scratch_m = '0;
      ie_m      = 1'b0;
      ready_m   = 1'b1;
      busy_m    = 1'b0;
      seen_low  = 1'b0;
   endtask

   task automatic end_test(string name);
      tests++;
      if (test_errs == 0) begin
         $display("PASS %s", name);
      end else begin
         $display("FAIL %s with %0d errors", name, test_errs);
         tests_failed++;
      end
      test_errs = 0;
   endtask

   task automatic summary(int assert_fails);
      $display("tests %0d passed %0d failed %0d errors %0d assertion failures %0d",
               tests, tests - tests_failed, tests_failed, err_total, assert_fails);
   endtask

   // rising sclk edges while selected
   always @(posedge sclk) begin
      if (!ss)
         rises++;
   end

   // sampled values are the ones before the edge
   always @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         clear_model();
      end else begin
         if (sel && read && data_out !== read_model(address))
            value_err("data_out", read_model(address), data_out);
         // pre-edge ss high after a low phase marks the end of TRAIL
         if (busy_m && seen_low && ss) begin
            if (rises != 32)
               plain_fail($sformatf("frame had %0d rising sclk edges, not 32", rises));
            if (low_cycles != 64 * CLK_DIV)
               plain_fail($sformatf("ss was low for %0d clk cycles", low_cycles));
            if (falls != frames)
               plain_fail("ss fell a different number of times than frames started");
            if (mosi_word !== tx_m)
               value_err("mosi_word", tx_m, mosi_word);
            rx_m     = miso_word;
            ready_m  = 1'b1;
            busy_m   = 1'b0;
            seen_low = 1'b0;
         end
         if (busy_m && !ss) begin
            seen_low = 1'b1;
            low_cycles++;
         end
         if (ss_q && !ss)
            falls++;
         ss_q = ss;
         if (sel && read && address == ADDR_RX)
            ready_m = 1'b0;
         if (sel && write) begin
            case (address)
               ADDR_INTR_EN: ie_m = data_in[0];
               ADDR_SCRATCH: scratch_m = data_in;
               ADDR_SOFT_RST: clear_model();
               ADDR_TX: begin
                  if (!busy_m) begin
                     tx_m       = data_in;
                     busy_m     = 1'b1;
                     ready_m    = 1'b0;
                     rises      = 0;
                     low_cycles = 0;
                     frames++;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // outputs checked mid cycle
   always @(negedge clk) begin
      if (!rst_int) begin
         if (interrupt !== (ie_m & ready_m))
            value_err("interrupt", {31'b0, ie_m & ready_m}, {31'b0, interrupt});
         if (!busy_m) begin
            if (ss !== 1'b1)
               value_err("ss", 32'h1, {31'b0, ss});
            if (sclk !== 1'b0)
               value_err("sclk", 32'h0, {31'b0, sclk});
            if (mosi !== 1'b0)
               value_err("mosi", 32'h0, {31'b0, mosi});
         end
      end
   end

endmodule

/* bench/spi_tb.sv */
// **************************************
// CLK_DIV 2, slave model drives miso on
// falling sclk, bus strobes one clk each
// **************************************

`timescale 1ns/10ps

module spi_tb import spi_pkg::*; ();

   localparam int CLK_DIV = 2;
   localparam int WD_CYCLES = 8 * 40 * 4 * CLK_DIV + 3000;

   logic        clk;
   logic        rst_int;
   logic        sel;
   logic        read;
   logic        write;
   spi_addr_t   address;
   spi_data_t   data_in;
   spi_data_t   data_out;
   logic        interrupt;
   logic        sclk;
   logic        ss;
   logic        mosi;
   logic        miso;
   logic [31:0] rng;
   logic [31:0] slave_rng;
   spi_data_t   miso_word;
   spi_data_t   mosi_word;
   int          idx;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   always #10 clk = ~clk;

   spi_master_top #(.CLK_DIV(CLK_DIV)) uut (
      .clk(clk), .rst_int(rst_int), .sel(sel), .read(read), .write(write),
      .address(address), .data_in(data_in), .data_out(data_out),
      .interrupt(interrupt), .sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso)
   );

   spi_checker #(.CLK_DIV(CLK_DIV)) chk (
      .clk(clk), .rst_int(rst_int), .sel(sel), .read(read), .write(write),
      .address(address), .data_in(data_in), .data_out(data_out),
      .interrupt(interrupt), .sclk(sclk), .ss(ss), .mosi(mosi),
      .mosi_word(mosi_word), .miso_word(miso_word)
   );

   bind spi_frame_seq spi_asserts u_asserts (
      .clk(clk), .rst_int(rst_int), .state(state), .ss(ss),
      .busy(frame.busy), .done(frame.done),
      .shift_tick(frame.shift_tick), .sample_tick(frame.sample_tick)
   );

   // slave model, new word per frame
   always @(negedge ss) begin
      slave_rng = xorshift(slave_rng);
      miso_word = slave_rng;
      mosi_word = '0;
      miso <= slave_rng[0];
      idx = 1;
   end

   always @(negedge sclk) begin
      if (!ss && idx < 32) begin
         miso <= miso_word[idx];
         idx++;
      end
   end

   always @(posedge sclk) begin
      if (!ss)
         mosi_word = {mosi, mosi_word[31:1]};
   end

   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("watchdog expired before the tests completed");
      $display("TESTS FAILED");
      $finish;
   end

   task automatic next_rand(output logic [31:0] v);
      rng = xorshift(rng);
      v = rng;
   endtask

   task automatic bus_write(input spi_addr_t a, input spi_data_t d);
      @(posedge clk);
      sel     <= 1'b1;
      write   <= 1'b1;
      address <= a;
      data_in <= d;
      @(posedge clk);
      sel   <= 1'b0;
      write <= 1'b0;
   endtask

   task automatic bus_read(input spi_addr_t a, output spi_data_t d);
      @(posedge clk);
      sel     <= 1'b1;
      read    <= 1'b1;
      address <= a;
      @(posedge clk);
      d = data_out;
      sel  <= 1'b0;
      read <= 1'b0;
   endtask

   // polls READY, each read is checked by chk
   task automatic wait_ready();
      spi_data_t d;
      int n;
      d = '0;
      n = 0;
      while (d[0] == 1'b0 && n < 2000) begin
         bus_read(ADDR_READY, d);
         n++;
      end
      if (d[0] == 1'b0)
         chk.plain_fail("ready did not rise after a frame");
   endtask

   task automatic read_all();
      spi_data_t d;
      bus_read(ADDR_VERSION, d);
      bus_read(ADDR_READY, d);
      bus_read(ADDR_RX, d);
      bus_read(ADDR_SCRATCH, d);
      bus_read(ADDR_INTR_EN, d);
      bus_read(ADDR_TX, d);
   endtask

   initial begin
      logic [31:0] w;
      spi_data_t   d;
      clk       = 1'b0;
      rst_int   = 1'b1;
      sel       = 1'b0;
      read      = 1'b0;
      write     = 1'b0;
      address   = '0;
      data_in   = '0;
      miso      = 1'b0;
      idx       = 32;
      miso_word = '0;
      mosi_word = '0;
      rng       = 32'hb697_f244;
      slave_rng = xorshift(32'hb697_f244);
      repeat (5) @(posedge clk);
      rst_int <= 1'b0;

      read_all();
      chk.end_test("reset values");

      repeat (8) begin
         next_rand(w);
         bus_write(ADDR_SCRATCH, w);
         bus_read(ADDR_SCRATCH, d);
         bus_read(3'd7, d);
      end
      chk.end_test("scratch register");

      next_rand(w);
      bus_write(ADDR_INTR_EN, {31'b0, w[0]});
      repeat (8) begin
         next_rand(w);
         bus_write(ADDR_TX, w);
         wait_ready();
         bus_read(ADDR_RX, d);
      end
      chk.end_test("random frames");

      bus_write(ADDR_INTR_EN, 32'h1);
      next_rand(w);
      bus_write(ADDR_TX, w);
      bus_read(ADDR_READY, d);
      next_rand(w);
      bus_write(ADDR_TX, w);
      bus_read(ADDR_TX, d);
      wait_ready();
      bus_read(ADDR_READY, d);
      bus_read(ADDR_RX, d);
      bus_read(ADDR_READY, d);
      chk.end_test("ready and interrupt");

      next_rand(w);
      bus_write(ADDR_SCRATCH, w);
      bus_write(ADDR_INTR_EN, 32'h1);
      next_rand(w);
      bus_write(ADDR_TX, w);
      repeat (20) @(posedge clk);
      next_rand(w);
      bus_write(ADDR_SOFT_RST, w);
      read_all();
      chk.end_test("soft reset");

      chk.summary(uut.u_seq.u_asserts.fail_cnt);
      if (chk.err_total == 0 && uut.u_seq.u_asserts.fail_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* compile.f */
verilog/spi_pkg.sv
verilog/spi_frame_if.sv
verilog/spi_regs.sv
verilog/spi_clk_gen.sv
verilog/spi_frame_seq.sv
verilog/spi_shifter.sv
verilog/spi_master_top.sv
bench/spi_asserts.sv
bench/spi_checker.sv
bench/spi_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f compile.f --top-module spi_tb \
      -Mdir obj_dir -o spi_sim; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/spi_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
   exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
   echo "simulation ended without a result"
   exit 1
fi

exit 0
